//--- filelist.f
verilog/bp_pkg.sv
verilog/bp_btb.sv
verilog/bp_gshare.sv
verilog/bp_csr_apb.sv
verilog/branch_predictor.sv
test/bp_assertions.sv
test/bp_tb.sv

//--- test/bp_tb.sv
// Self-checking testbench for the branch predictor with seeded random fetch, resolve and APB traffic
module bp_tb;

    localparam int num_btb_entries = 4;
    localparam int num_ghr_bits    = 5;
    localparam int idx_bits        = $clog2(num_btb_entries);
    localparam int apb_timeout     = 16;

    logic                    clk;
    logic                    reset_i;
    logic [31:0]             fetch_pc_i;
    logic                    pred_taken_o;
    logic [31:0]             pred_target_o;
    logic [num_ghr_bits-1:0] pred_pht_index_o;
    logic                    res_valid_i;
    logic [31:0]             res_pc_i;
    logic [6:0]              res_op_i;
    logic [31:0]             res_target_i;
    logic                    res_taken_i;
    logic [num_ghr_bits-1:0] res_pht_index_i;
    logic                    res_mispredict_i;
    logic                    psel_i;
    logic                    penable_i;
    logic                    pwrite_i;
    logic [3:0]              paddr_i;
    logic [31:0]             pwdata_i;
    logic [31:0]             prdata_o;
    logic                    pready_o;
    logic                    pslverr_o;

    int errors;
    int timeouts;

    // Reference model state
    logic [31:0]             m_tag    [num_btb_entries];
    logic [31:0]             m_target [num_btb_entries];
    logic                    m_jump   [num_btb_entries];
    logic                    m_valid  [num_btb_entries];
    logic [1:0]              m_pht    [1 << num_ghr_bits];
    logic [num_ghr_bits-1:0] m_ghr;
    logic                    m_enable;
    logic [31:0]             m_updates;
    logic [31:0]             m_mispredicts;

    branch_predictor #(
        .num_btb_entries(num_btb_entries),
        .num_ghr_bits   (num_ghr_bits)
    ) i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Small pool, four indices with three tags each
    function automatic logic [31:0] pick_pc();
        return 32'h1000 + ($urandom % 4) * 4 + ($urandom % 3) * 32'h100;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAILED %s: got 0x%08h expected 0x%08h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_outputs();
        logic [idx_bits-1:0]     idx;
        logic [num_ghr_bits-1:0] pidx;
        logic                    exp_taken;
        logic [31:0]             exp_target;
        idx        = fetch_pc_i[idx_bits+1:2];
        pidx       = fetch_pc_i[num_ghr_bits+1:2] ^ m_ghr;
        exp_taken  = 1'b0;
        exp_target = fetch_pc_i + 32'd4;
        if (m_enable && m_valid[idx] && m_tag[idx] == fetch_pc_i) begin
            exp_target = m_target[idx];
            exp_taken  = m_jump[idx] ? 1'b1 : m_pht[pidx][1];
        end
        check_value("pred_taken_o", pred_taken_o, exp_taken);
        check_value("pred_target_o", pred_target_o, exp_target);
        check_value("pred_pht_index_o", pred_pht_index_o, pidx);
    endtask

    // Applies the inputs seen at the clock edge to the model
    task automatic update_model();
        logic ctrl_write;
        logic is_jump;
        logic is_branch;
        ctrl_write = psel_i && penable_i && pwrite_i && paddr_i == bp_pkg::reg_ctrl;
        is_jump    = res_op_i == bp_pkg::op_jal || res_op_i == bp_pkg::op_jalr;
        is_branch  = res_op_i == bp_pkg::op_branch;
        if (res_valid_i && (is_jump || is_branch)) begin
            m_updates = m_updates + 1;
            if (res_mispredict_i) m_mispredicts = m_mispredicts + 1;
            if (!(ctrl_write && pwdata_i[bp_pkg::ctrl_btb_flush_bit])) begin
                m_valid[res_pc_i[idx_bits+1:2]]  = 1'b1;
                m_tag[res_pc_i[idx_bits+1:2]]    = res_pc_i;
                m_target[res_pc_i[idx_bits+1:2]] = res_target_i;
                m_jump[res_pc_i[idx_bits+1:2]]   = is_jump;
            end
        end
        if (res_valid_i && is_branch) begin
            if (res_taken_i && m_pht[res_pht_index_i] != 2'b11)
                m_pht[res_pht_index_i] = m_pht[res_pht_index_i] + 2'b01;
            else if (!res_taken_i && m_pht[res_pht_index_i] != 2'b00)
                m_pht[res_pht_index_i] = m_pht[res_pht_index_i] - 2'b01;
            m_ghr = {m_ghr[num_ghr_bits-2:0], res_taken_i};
        end
        if (ctrl_write) begin
            m_enable = pwdata_i[bp_pkg::ctrl_enable_bit];
            if (pwdata_i[bp_pkg::ctrl_btb_flush_bit]) begin
                foreach (m_valid[i]) m_valid[i] = 1'b0;
            end
            if (pwdata_i[bp_pkg::ctrl_ghr_clear_bit]) m_ghr = '0;
        end
    endtask

    // Inputs are set one unit after an edge, checked one unit before the next
    task automatic next_cycle();
        #2;
        check_outputs();
        @(posedge clk);
        update_model();
        #1;
    endtask

    task automatic lookup_cycle(input logic [31:0] pc);
        fetch_pc_i  = pc;
        res_valid_i = 1'b0;
        next_cycle();
    endtask

    task automatic resolve_cycle(input logic [31:0] pc, input logic [6:0] op,
                                 input logic [31:0] target, input logic taken);
        fetch_pc_i       = pick_pc();
        res_valid_i      = 1'b1;
        res_pc_i         = pc;
        res_op_i         = op;
        res_target_i     = target;
        res_taken_i      = taken;
        res_pht_index_i  = pc[num_ghr_bits+1:2] ^ m_ghr;
        res_mispredict_i = $urandom % 2;
        next_cycle();
    endtask

    task automatic random_cycle(input logic branch_only);
        logic [6:0] op;
        case ($urandom % 4)
            0: op = bp_pkg::op_jal;
            1: op = bp_pkg::op_jalr;
            2: op = bp_pkg::op_branch;
            default: op = 7'b0110011;
        endcase
        if (branch_only) op = bp_pkg::op_branch;
        if ($urandom % 2) begin
            resolve_cycle(pick_pc(), op, $urandom & 32'hffff_fffc,
                          (op == bp_pkg::op_branch) ? 1'($urandom % 2) : 1'b1);
        end else begin
            lookup_cycle(pick_pc());
        end
    endtask

    task automatic apb_transfer(input logic wr, input logic [3:0] addr, input logic [31:0] data);
        int          cnt;
        logic        exp_err;
        logic [31:0] exp_rdata;
        fetch_pc_i  = pick_pc();
        res_valid_i = 1'b0;
        psel_i      = 1'b1;
        penable_i   = 1'b0;
        pwrite_i    = wr;
        paddr_i     = addr;
        pwdata_i    = data;
        next_cycle();
        penable_i = 1'b1;
        cnt = 0;
        #2;
        while (!pready_o && cnt < apb_timeout) begin
            @(posedge clk);
            update_model();
            #3;
            cnt++;
        end
        if (!pready_o) begin
            $display("APB transfer to offset 0x%h timed out waiting for pready_o", addr);
            timeouts++;
        end else begin
            exp_err = (addr > bp_pkg::reg_ghr) || (wr && addr != bp_pkg::reg_ctrl);
            check_value("pslverr_o", pslverr_o, exp_err);
            if (!wr && !exp_err) begin
                case (addr)
                    bp_pkg::reg_ctrl:        exp_rdata = 32'(m_enable);
                    bp_pkg::reg_updates:     exp_rdata = m_updates;
                    bp_pkg::reg_mispredicts: exp_rdata = m_mispredicts;
                    bp_pkg::reg_ghr:         exp_rdata = 32'(m_ghr);
                    default:                 exp_rdata = 32'h0;
                endcase
                check_value("prdata_o", prdata_o, exp_rdata);
            end
        end
        check_outputs();
        @(posedge clk);
        update_model();
        #1;
        psel_i    = 1'b0;
        penable_i = 1'b0;
        pwrite_i  = 1'b0;
    endtask

    initial begin
        void'($urandom(32'hcba9));
        errors = 0;
        timeouts = 0;
        reset_i = 1'b1;
        fetch_pc_i = 32'h1000;
        res_valid_i = 1'b0;
        res_pc_i = '0;
        res_op_i = '0;
        res_target_i = '0;
        res_taken_i = 1'b0;
        res_pht_index_i = '0;
        res_mispredict_i = 1'b0;
        psel_i = 1'b0;
        penable_i = 1'b0;
        pwrite_i = 1'b0;
        paddr_i = '0;
        pwdata_i = '0;
        foreach (m_valid[i]) m_valid[i] = 1'b0;
        foreach (m_pht[i]) m_pht[i] = 2'b00;
        m_ghr = '0;
        m_enable = 1'b1;
        m_updates = '0;
        m_mispredicts = '0;
        repeat (8) @(posedge clk);
        #1 reset_i = 1'b0;

        // Empty BTB misses everywhere and statistics start at zero
        repeat (12) lookup_cycle(pick_pc());
        apb_transfer(1'b0, bp_pkg::reg_ctrl, '0);
        apb_transfer(1'b0, bp_pkg::reg_updates, '0);
        apb_transfer(1'b0, bp_pkg::reg_mispredicts, '0);
        apb_transfer(1'b0, bp_pkg::reg_ghr, '0);

        // Jump hits, then an aliasing PC with another tag
        resolve_cycle(32'h1004, bp_pkg::op_jal, 32'h0000_2340, 1'b1);
        lookup_cycle(32'h1004);
        lookup_cycle(32'h1104);
        resolve_cycle(32'h1208, bp_pkg::op_jalr, 32'h0000_8000, 1'b1);
        lookup_cycle(32'h1208);
        lookup_cycle(32'h1008);
        repeat (200) random_cycle(1'b0);

        // Branch-only traffic trains the counters and history
        repeat (300) random_cycle(1'b1);
        apb_transfer(1'b0, bp_pkg::reg_ghr, '0);

        // Disable with a known jump entry present
        resolve_cycle(32'h1004, bp_pkg::op_jal, 32'h0000_2340, 1'b1);
        apb_transfer(1'b1, bp_pkg::reg_ctrl, 32'h0);
        lookup_cycle(32'h1004);
        repeat (20) random_cycle(1'b0);
        apb_transfer(1'b1, bp_pkg::reg_ctrl, 32'h1);
        repeat (20) random_cycle(1'b0);

        // Known entry and nonzero history ahead of the flush and the clear
        resolve_cycle(32'h1004, bp_pkg::op_jal, 32'h0000_2340, 1'b1);
        resolve_cycle(32'h100c, bp_pkg::op_branch, 32'h0000_4000, 1'b1);
        apb_transfer(1'b1, bp_pkg::reg_ctrl, 32'h3);
        lookup_cycle(32'h1004);
        repeat (8) lookup_cycle(pick_pc());
        apb_transfer(1'b1, bp_pkg::reg_ctrl, 32'h5);
        apb_transfer(1'b0, bp_pkg::reg_ghr, '0);
        apb_transfer(1'b0, bp_pkg::reg_ctrl, '0);
        repeat (100) random_cycle(1'b0);

        // Read-only and unmapped offsets
        apb_transfer(1'b1, bp_pkg::reg_updates, 32'hffff_ffff);
        apb_transfer(1'b1, bp_pkg::reg_mispredicts, 32'hffff_ffff);
        apb_transfer(1'b1, bp_pkg::reg_ghr, 32'hffff_ffff);
        apb_transfer(1'b1, 4'h6, 32'hffff_ffff);
        apb_transfer(1'b1, 4'hd, 32'hffff_fffe);
        apb_transfer(1'b0, 4'hf, '0);
        apb_transfer(1'b0, bp_pkg::reg_updates, '0);
        apb_transfer(1'b0, bp_pkg::reg_mispredicts, '0);
        apb_transfer(1'b0, bp_pkg::reg_ghr, '0);
        apb_transfer(1'b0, bp_pkg::reg_ctrl, '0);

        $display("Run finished with %0d errors and %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

//--- test/bp_assertions.sv
// Concurrent protocol and prediction checks, bound onto the branch predictor top level
module bp_assertions (
    input logic        clk,
    input logic        reset_i,
    input logic        psel_i,
    input logic        penable_i,
    input logic        pready_o,
    input logic        pslverr_o,
    input logic        enable_i,
    input logic [31:0] fetch_pc_i,
    input logic        pred_taken_o,
    input logic [31:0] pred_target_o
);

    // Zero wait states, so the access phase always completes
    ready_in_access: assert property (@(posedge clk) disable iff (reset_i)
        (psel_i && penable_i) |-> pready_o)
        else $error("pready_o low during an APB access phase");

    error_only_in_access: assert property (@(posedge clk) disable iff (reset_i)
        !(psel_i && penable_i) |-> !pslverr_o)
        else $error("pslverr_o high outside an APB access phase");

    // Disabled predictor falls through to the sequential PC
    sequential_when_disabled: assert property (@(posedge clk) disable iff (reset_i)
        (!pred_taken_o && !enable_i) |-> (pred_target_o == fetch_pc_i + 32'd4))
        else $error("pred_target_o is not the sequential PC while disabled");

endmodule

bind branch_predictor bp_assertions i_assertions (
    .clk           (clk),
    .reset_i       (reset_i),
    .psel_i        (psel_i),
    .penable_i     (penable_i),
    .pready_o      (pready_o),
    .pslverr_o     (pslverr_o),
    .enable_i      (enable),
    .fetch_pc_i    (fetch_pc_i),
    .pred_taken_o  (pred_taken_o),
    .pred_target_o (pred_target_o)
);

//--- verilog/branch_predictor.sv
// Fetch-stage branch predictor top level joining the BTB, gshare and APB register block
module branch_predictor #(
    parameter int num_btb_entries = 4,
    parameter int num_ghr_bits    = 5
) (
    input  logic                                clk,
    input  logic                                reset_i,
    // Fetch
    input  logic [bp_pkg::pc_width-1:0]         fetch_pc_i,
    output logic                                pred_taken_o,
    output logic [bp_pkg::pc_width-1:0]         pred_target_o,
    output logic [num_ghr_bits-1:0]             pred_pht_index_o,
    // Resolve from execute
    input  logic                                res_valid_i,
    input  logic [bp_pkg::pc_width-1:0]         res_pc_i,
    input  logic [6:0]                          res_op_i,
    input  logic [bp_pkg::pc_width-1:0]         res_target_i,
    input  logic                                res_taken_i,
    input  logic [num_ghr_bits-1:0]             res_pht_index_i,
    input  logic                                res_mispredict_i,
    // APB
    input  logic                                psel_i,
    input  logic                                penable_i,
    input  logic                                pwrite_i,
    input  logic [bp_pkg::apb_addr_width-1:0]   paddr_i,
    input  logic [bp_pkg::apb_data_width-1:0]   pwdata_i,
    output logic [bp_pkg::apb_data_width-1:0]   prdata_o,
    output logic                                pready_o,
    output logic                                pslverr_o
);

    logic                    enable;
    logic                    btb_flush;
    logic                    ghr_clear;
    logic                    pht_taken;
    logic [num_ghr_bits-1:0] ghr;

    bp_btb #(
        .num_btb_entries(num_btb_entries)
    ) i_btb (
        .clk           (clk),
        .reset_i       (reset_i),
        .fetch_pc_i    (fetch_pc_i),
        .enable_i      (enable),
        .flush_i       (btb_flush),
        .pht_taken_i   (pht_taken),
        .res_valid_i   (res_valid_i),
        .res_pc_i      (res_pc_i),
        .res_op_i      (res_op_i),
        .res_target_i  (res_target_i),
        .pred_taken_o  (pred_taken_o),
        .pred_target_o (pred_target_o)
    );

    bp_gshare #(
        .num_ghr_bits(num_ghr_bits)
    ) i_gshare (
        .clk             (clk),
        .reset_i         (reset_i),
        .fetch_pc_i      (fetch_pc_i),
        .ghr_clear_i     (ghr_clear),
        .res_valid_i     (res_valid_i),
        .res_op_i        (res_op_i),
        .res_taken_i     (res_taken_i),
        .res_pht_index_i (res_pht_index_i),
        .pht_taken_o     (pht_taken),
        .pht_index_o     (pred_pht_index_o),
        .ghr_o           (ghr)
    );

    bp_csr_apb #(
        .num_ghr_bits(num_ghr_bits)
    ) i_csr (
        .clk              (clk),
        .reset_i          (reset_i),
        .psel_i           (psel_i),
        .penable_i        (penable_i),
        .pwrite_i         (pwrite_i),
        .paddr_i          (paddr_i),
        .pwdata_i         (pwdata_i),
        .res_valid_i      (res_valid_i),
        .res_op_i         (res_op_i),
        .res_mispredict_i (res_mispredict_i),
        .ghr_i            (ghr),
        .prdata_o         (prdata_o),
        .pready_o         (pready_o),
        .pslverr_o        (pslverr_o),
        .enable_o         (enable),
        .btb_flush_o      (btb_flush),
        .ghr_clear_o      (ghr_clear)
    );

endmodule

//--- verilog/bp_csr_apb.sv
// APB register block with predictor control, flush and clear pulses, and resolve statistics
module bp_csr_apb #(
    parameter int num_ghr_bits = 5
) (
    input  logic                                clk,
    input  logic                                reset_i,
    input  logic                                psel_i,
    input  logic                                penable_i,
    input  logic                                pwrite_i,
    input  logic [bp_pkg::apb_addr_width-1:0]   paddr_i,
    input  logic [bp_pkg::apb_data_width-1:0]   pwdata_i,
    input  logic                                res_valid_i,
    input  logic [6:0]                          res_op_i,
    input  logic                                res_mispredict_i,
    input  logic [num_ghr_bits-1:0]             ghr_i,
    output logic [bp_pkg::apb_data_width-1:0]   prdata_o,
    output logic                                pready_o,
    output logic                                pslverr_o,
    output logic                                enable_o,
    output logic                                btb_flush_o,
    output logic                                ghr_clear_o
);

    logic        access;
    logic        bad_addr;
    logic        ctrl_write;
    logic        res_ctl;
    logic        enable_q;
    logic [31:0] updates_q;
    logic [31:0] mispredicts_q;

    // No wait states
    assign pready_o = 1'b1;
    assign access   = psel_i && penable_i;

    // Anything past the history register is unmapped
    assign bad_addr = paddr_i > bp_pkg::reg_ghr;

    // Only the control register takes writes
    assign pslverr_o  = access && (bad_addr || (pwrite_i && paddr_i != bp_pkg::reg_ctrl));
    assign ctrl_write = access && pwrite_i && (paddr_i == bp_pkg::reg_ctrl);

    // Flush and clear act on the edge that ends the access phase
    assign btb_flush_o = ctrl_write && pwdata_i[bp_pkg::ctrl_btb_flush_bit];
    assign ghr_clear_o = ctrl_write && pwdata_i[bp_pkg::ctrl_ghr_clear_bit];

    assign enable_o = enable_q;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            enable_q <= 1'b1;
        end else if (ctrl_write) begin
            enable_q <= pwdata_i[bp_pkg::ctrl_enable_bit];
        end
    end

    // Any resolved control transfer counts as an update
    assign res_ctl = res_valid_i && ((res_op_i == bp_pkg::op_jal) ||
                                     (res_op_i == bp_pkg::op_jalr) ||
                                     (res_op_i == bp_pkg::op_branch));

    // Statistics wrap around
    always_ff @(posedge clk) begin
        if (reset_i) begin
            updates_q     <= '0;
            mispredicts_q <= '0;
        end else if (res_ctl) begin
            updates_q <= updates_q + 32'd1;
            if (res_mispredict_i) begin
                mispredicts_q <= mispredicts_q + 32'd1;
            end
        end
    end

    // Read mux
    always_comb begin
        prdata_o = '0;
        case (paddr_i)
            bp_pkg::reg_ctrl: begin
                prdata_o[bp_pkg::ctrl_enable_bit] = enable_q;
            end
            bp_pkg::reg_updates: begin
                prdata_o = updates_q;
            end
            bp_pkg::reg_mispredicts: begin
                prdata_o = mispredicts_q;
            end
            bp_pkg::reg_ghr: begin
                prdata_o[num_ghr_bits-1:0] = ghr_i;
            end
            default: begin
                prdata_o = '0;
            end
        endcase
    end

endmodule

//--- verilog/bp_gshare.sv
// Gshare direction predictor with global history and a table of saturating counters
module bp_gshare #(
    parameter int num_ghr_bits = 5
) (
    input  logic                          clk,
    input  logic                          reset_i,
    input  logic [bp_pkg::pc_width-1:0]   fetch_pc_i,
    input  logic                          ghr_clear_i,
    input  logic                          res_valid_i,
    input  logic [6:0]                    res_op_i,
    input  logic                          res_taken_i,
    input  logic [num_ghr_bits-1:0]       res_pht_index_i,
    output logic                          pht_taken_o,
    output logic [num_ghr_bits-1:0]       pht_index_o,
    output logic [num_ghr_bits-1:0]       ghr_o
);

    localparam int num_pht_entries = 1 << num_ghr_bits;

    bp_pkg::ctr_t            pht_q [num_pht_entries];
    logic [num_ghr_bits-1:0] ghr_q;
    logic                    train;
    bp_pkg::ctr_t            res_ctr;

    // Only conditional branches train direction state
    assign train = res_valid_i && (res_op_i == bp_pkg::op_branch);

    // Fetch-time index, handed to the core and returned at resolve
    assign pht_index_o = fetch_pc_i[num_ghr_bits+1:2] ^ ghr_q;
    assign pht_taken_o = pht_q[pht_index_o][1];
    assign ghr_o       = ghr_q;

    assign res_ctr = pht_q[res_pht_index_i];

    // Counter table, starts strongly not taken
    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < num_pht_entries; i++) begin
                pht_q[i] <= '0;
            end
        end else if (train) begin
            if (res_taken_i) begin
                if (res_ctr != 2'b11) begin
                    pht_q[res_pht_index_i] <= res_ctr + 2'b01;
                end
            end else begin
                if (res_ctr != 2'b00) begin
                    pht_q[res_pht_index_i] <= res_ctr - 2'b01;
                end
            end
        end
    end

    // History shifts left with the actual outcome in bit 0
    always_ff @(posedge clk) begin
        if (reset_i || ghr_clear_i) begin
            ghr_q <= '0;
        end else if (train) begin
            ghr_q <= {ghr_q[num_ghr_bits-2:0], res_taken_i};
        end
    end

endmodule

//--- verilog/bp_btb.sv
// Direct-mapped branch target buffer; gives the predicted direction and next PC for a fetch PC
module bp_btb #(
    parameter int num_btb_entries = 4
) (
    input  logic                          clk,
    input  logic                          reset_i,
    input  logic [bp_pkg::pc_width-1:0]   fetch_pc_i,
    input  logic                          enable_i,
    input  logic                          flush_i,
    input  logic                          pht_taken_i,
    input  logic                          res_valid_i,
    input  logic [bp_pkg::pc_width-1:0]   res_pc_i,
    input  logic [6:0]                    res_op_i,
    input  logic [bp_pkg::pc_width-1:0]   res_target_i,
    output logic                          pred_taken_o,
    output logic [bp_pkg::pc_width-1:0]   pred_target_o
);

    localparam int idx_bits = $clog2(num_btb_entries);

    // Entry storage
    logic [bp_pkg::pc_width-1:0] tag_q    [num_btb_entries];
    logic [bp_pkg::pc_width-1:0] target_q [num_btb_entries];
    logic                        jump_q   [num_btb_entries];
    logic                        branch_q [num_btb_entries];
    logic                        valid_q  [num_btb_entries];

    logic [idx_bits-1:0] fetch_idx;
    logic [idx_bits-1:0] res_idx;
    logic                res_is_jump;
    logic                res_is_branch;
    logic                write_en;
    logic                hit;

    assign fetch_idx = fetch_pc_i[idx_bits+1:2];
    assign res_idx   = res_pc_i[idx_bits+1:2];

    // Classify the resolved instruction
    assign res_is_jump   = (res_op_i == bp_pkg::op_jal) || (res_op_i == bp_pkg::op_jalr);
    assign res_is_branch = (res_op_i == bp_pkg::op_branch);

    // A flush in the same cycle suppresses the write
    assign write_en = res_valid_i && (res_is_jump || res_is_branch) && !flush_i;

    // Valid bits carry the entry state
    always_ff @(posedge clk) begin
        if (reset_i || flush_i) begin
            for (int i = 0; i < num_btb_entries; i++) begin
                valid_q[i] <= 1'b0;
            end
        end else if (write_en) begin
            valid_q[res_idx] <= 1'b1;
        end
    end

    // Entry payload, written together with the valid bit
    always_ff @(posedge clk) begin
        if (write_en) begin
            tag_q[res_idx]    <= res_pc_i;
            target_q[res_idx] <= res_target_i;
            jump_q[res_idx]   <= res_is_jump;
            branch_q[res_idx] <= res_is_branch;
        end
    end

    // Full-PC tag compare
    assign hit = enable_i && valid_q[fetch_idx] && (tag_q[fetch_idx] == fetch_pc_i);

    // Next-PC selection
    always_comb begin
        pred_taken_o  = 1'b0;
        pred_target_o = fetch_pc_i + 32'd4;
        if (hit) begin
            if (jump_q[fetch_idx]) begin
                // Jumps are always taken
                pred_taken_o  = 1'b1;
                pred_target_o = target_q[fetch_idx];
            end else if (branch_q[fetch_idx]) begin
                pred_taken_o  = pht_taken_i;
                pred_target_o = target_q[fetch_idx];
            end
        end
    end

endmodule

//--- verilog/bp_pkg.sv
// Shared opcodes, counter type and APB register map for the branch predictor; referenced by scope
package bp_pkg;

    // RISC-V major opcodes of the control-transfer instructions
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_jalr   = 7'b1100111;
    localparam logic [6:0] op_branch = 7'b1100011;

    // Instruction address width
    localparam int pc_width = 32;

    // APB data width
    localparam int apb_data_width = 32;

    // APB address width, byte offsets
    localparam int apb_addr_width = 4;

    // 2-bit saturating counter, upper bit set means taken
    typedef logic [1:0] ctr_t;

    // Register byte offsets
    localparam logic [apb_addr_width-1:0] reg_ctrl        = 4'h0;
    localparam logic [apb_addr_width-1:0] reg_updates     = 4'h4;
    localparam logic [apb_addr_width-1:0] reg_mispredicts = 4'h8;
    localparam logic [apb_addr_width-1:0] reg_ghr         = 4'hc;

    // Control register bits
    localparam int ctrl_enable_bit    = 0;
    localparam int ctrl_btb_flush_bit = 1;
    localparam int ctrl_ghr_clear_bit = 2;

endpackage
